// File: dma_ctrl_csr.f
logic/dma_csr_map_pkg.sv
logic/dma_csr_ident_pkg.sv
logic/csr_access_decode.sv
logic/csr_register_bank.sv
logic/csr_read_return.sv
logic/dma_ctrl_csr_top.sv
verification/tb_clock_gen.sv
verification/dma_ctrl_csr_tb.sv

// File: logic/csr_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_i,
    input  logic                                  wr_en_i,
    input  logic [dma_csr_map_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] wr_data_i,
    output logic [dma_csr_map_pkg::SEL_W-1:0]      sel_o,
    output logic                                  wr_o,
    output logic                                  rd_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] wr_data_o
);

    import dma_csr_map_pkg::*;

    logic [SEL_W-1:0] sel_d;

    // Address compare, the only place the map is consulted
    always_comb begin
        sel_d                = '0;
        sel_d[SEL_IDENT]     = (addr_i == REG_IDENT);
        sel_d[SEL_WR_START]  = (addr_i == REG_WR_START);
        sel_d[SEL_BUF_QUEUE] = (addr_i == REG_BUF_QUEUE);
        sel_d[SEL_DAC]       = (addr_i == REG_DAC);
        sel_d[SEL_CFG1_HI]   = (addr_i == REG_CFG1_HI);
        sel_d[SEL_CFG2]      = (addr_i == REG_CFG2);
        sel_d[SEL_PKT_COUNT] = (addr_i == REG_PKT_COUNT);
        sel_d[SEL_FRAME_LEN] = (addr_i == REG_FRAME_LEN);
        sel_d[SEL_TEST]      = (addr_i == REG_TEST);
    end

    //----------------------------------------------------------------------
    // Request stage
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_o  <= 1'b0;
            rd_o  <= 1'b0;
            sel_o <= '0;
        end else begin
            wr_o <= req_i & wr_en_i;   // One-cycle qualifiers
            rd_o <= req_i & ~wr_en_i;
            if (req_i) begin
                sel_o <= sel_d;        // Held until the next access
            end
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (req_i && wr_en_i) begin
            wr_data_o <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/csr_read_return.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_return (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [dma_csr_map_pkg::SEL_W-1:0]      sel_i,
    input  logic                                  rd_i,
    input  logic                                  wr_i,
    input  logic                                  init_rst_i,
    input  logic                                  mwr_start_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] dac_data_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] config_1_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] config_2_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] pkt_count_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] buf_head_i,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] rd_data_o,
    output logic                                  rd_valid_o,
    output logic                                  buf_push_o,
    output logic                                  buf_pop_o
);

    import dma_csr_map_pkg::*;
    import dma_csr_ident_pkg::*;

    logic [CSR_DATA_W-1:0] rd_word;

    //----------------------------------------------------------------------
    // Read mux over the one-hot select
    //----------------------------------------------------------------------
    always_comb begin
        rd_word = '0;  // Unmapped index reads as zero
        if (sel_i[SEL_IDENT]) begin
            rd_word = {FPGA_FAMILY, 4'h0, INTERFACE_TYPE, VERSION_NUMBER, 7'h00, init_rst_i};
        end
        if (sel_i[SEL_WR_START]) begin
            rd_word = CSR_DATA_W'(mwr_start_i);
        end
        if (sel_i[SEL_BUF_QUEUE]) begin
            rd_word = buf_head_i;  // Head before the pop
        end
        if (sel_i[SEL_DAC]) begin
            rd_word = dac_data_i;
        end
        if (sel_i[SEL_CFG1_HI]) begin
            rd_word = CSR_DATA_W'(config_1_i[CSR_DATA_W-1 -: CFG1_HI_W]);
        end
        if (sel_i[SEL_CFG2]) begin
            rd_word = config_2_i;
        end
        if (sel_i[SEL_PKT_COUNT]) begin
            rd_word = pkt_count_i;
        end
        if (sel_i[SEL_FRAME_LEN]) begin
            rd_word = CSR_DATA_W'(config_1_i[FRAME_LEN_W-1:0]);
        end
        if (sel_i[SEL_TEST]) begin
            rd_word = TEST_PATTERN;
        end
    end

    // Output stage, all pulses line up with rd_valid_o
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o  <= '0;
            rd_valid_o <= 1'b0;
            buf_push_o <= 1'b0;
            buf_pop_o  <= 1'b0;
        end else begin
            rd_valid_o <= rd_i;
            buf_push_o <= wr_i & sel_i[SEL_BUF_QUEUE];
            buf_pop_o  <= rd_i & sel_i[SEL_BUF_QUEUE];
            if (rd_i) begin
                rd_data_o <= rd_word;  // Holds until the next read
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/csr_register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module csr_register_bank (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [dma_csr_map_pkg::SEL_W-1:0]      sel_i,
    input  logic                                  wr_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] wr_data_i,
    output logic                                  init_rst_o,
    output logic                                  mwr_start_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] buf_addr_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] dac_data_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] config_1_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] config_2_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] pkt_count_o
);

    import dma_csr_map_pkg::*;

    // Per-register write enables
    logic wr_ident;
    logic wr_start;
    logic wr_queue;
    logic wr_dac;
    logic wr_cfg1_hi;
    logic wr_cfg2;
    logic wr_pkt_count;
    logic wr_frame_len;

    assign wr_ident     = wr_i & sel_i[SEL_IDENT];
    assign wr_start     = wr_i & sel_i[SEL_WR_START];
    assign wr_queue     = wr_i & sel_i[SEL_BUF_QUEUE];
    assign wr_dac       = wr_i & sel_i[SEL_DAC];
    assign wr_cfg1_hi   = wr_i & sel_i[SEL_CFG1_HI];
    assign wr_cfg2      = wr_i & sel_i[SEL_CFG2];
    assign wr_pkt_count = wr_i & sel_i[SEL_PKT_COUNT];
    assign wr_frame_len = wr_i & sel_i[SEL_FRAME_LEN];

    //----------------------------------------------------------------------
    // Control bits
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o  <= 1'b0;
            mwr_start_o <= 1'b0;
        end else begin
            if (wr_ident) begin
                init_rst_o <= wr_data_i[0];
            end

            // Initiator reset also aborts a running write
            if (wr_ident && wr_data_i[0]) begin
                mwr_start_o <= 1'b0;
            end else if (wr_start) begin
                mwr_start_o <= wr_data_i[0];
            end
        end
    end

    //----------------------------------------------------------------------
    // Data words
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_addr_o  <= '0;
            dac_data_o  <= DAC_RESET;
            config_1_o  <= CFG1_RESET;
            config_2_o  <= CFG2_RESET;
            pkt_count_o <= PKT_COUNT_RESET;
        end else begin
            if (wr_queue) begin
                buf_addr_o <= wr_data_i;   // Address pushed to the buffer queue
            end

            if (wr_dac) begin
                dac_data_o <= wr_data_i;
            end

            // Two windows onto one word
            if (wr_cfg1_hi) begin
                config_1_o[CSR_DATA_W-1 -: CFG1_HI_W] <= wr_data_i[CFG1_HI_W-1:0];
            end
            if (wr_frame_len) begin
                config_1_o[FRAME_LEN_W-1:0] <= wr_data_i[FRAME_LEN_W-1:0];
            end

            if (wr_cfg2) begin
                config_2_o <= wr_data_i;
            end

            if (wr_pkt_count) begin
                pkt_count_o <= wr_data_i;  // Packets per buffer
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dma_csr_ident_pkg.sv
`default_nettype none

package dma_csr_ident_pkg;

    //----------------------------------------------------------------------
    // Identification word fields
    //----------------------------------------------------------------------
    localparam logic [7:0] VERSION_NUMBER = 8'h16;
    localparam logic [3:0] INTERFACE_TYPE = 4'h2;  // Data path width code
    localparam logic [7:0] FPGA_FAMILY    = 8'h14;

    // Fixed word for bus sanity checks
    localparam logic [31:0] TEST_PATTERN = 32'hABD0_FFCE;

endpackage

`default_nettype wire

// File: logic/dma_csr_map_pkg.sv
`default_nettype none

package dma_csr_map_pkg;

    //----------------------------------------------------------------------
    // Word and index widths
    //----------------------------------------------------------------------
    localparam int CSR_DATA_W = 32;
    localparam int CSR_ADDR_W = 7;

    // Register indices on the host bus
    localparam logic [CSR_ADDR_W-1:0] REG_IDENT     = 7'd0;
    localparam logic [CSR_ADDR_W-1:0] REG_WR_START  = 7'd1;
    localparam logic [CSR_ADDR_W-1:0] REG_BUF_QUEUE = 7'd2;
    localparam logic [CSR_ADDR_W-1:0] REG_DAC       = 7'd3;
    localparam logic [CSR_ADDR_W-1:0] REG_CFG1_HI   = 7'd4;
    localparam logic [CSR_ADDR_W-1:0] REG_CFG2      = 7'd5;
    localparam logic [CSR_ADDR_W-1:0] REG_PKT_COUNT = 7'd6;
    localparam logic [CSR_ADDR_W-1:0] REG_FRAME_LEN = 7'd7;
    localparam logic [CSR_ADDR_W-1:0] REG_TEST      = 7'd9;  // Index 8 left unmapped

    // Bit positions in the one-hot select bus, one per mapped register
    localparam int SEL_W         = 9;
    localparam int SEL_IDENT     = 0;
    localparam int SEL_WR_START  = 1;
    localparam int SEL_BUF_QUEUE = 2;
    localparam int SEL_DAC       = 3;
    localparam int SEL_CFG1_HI   = 4;
    localparam int SEL_CFG2      = 5;
    localparam int SEL_PKT_COUNT = 6;
    localparam int SEL_FRAME_LEN = 7;
    localparam int SEL_TEST      = 8;

    // Config register 1 is split into an upper field and the frame length
    localparam int CFG1_HI_W   = 19;
    localparam int FRAME_LEN_W = 13;

    //----------------------------------------------------------------------
    // Reset values
    //----------------------------------------------------------------------
    localparam logic [CSR_DATA_W-1:0] DAC_RESET       = 32'h8080_8080;
    localparam logic [CSR_DATA_W-1:0] CFG1_RESET      = 32'h0002_1FFF; // Upper 0x10, len 0x1FFF
    localparam logic [CSR_DATA_W-1:0] CFG2_RESET      = 32'h0002_0000;
    localparam logic [CSR_DATA_W-1:0] PKT_COUNT_RESET = 32'h0000_8000;

endpackage

`default_nettype wire

// File: logic/dma_ctrl_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_csr_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_i,
    input  logic                                  wr_en_i,
    input  logic [dma_csr_map_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] wr_data_i,
    input  logic [dma_csr_map_pkg::CSR_DATA_W-1:0] buf_head_i,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] rd_data_o,
    output logic                                  rd_valid_o,
    output logic                                  init_rst_o,
    output logic                                  mwr_start_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] buf_addr_o,
    output logic                                  buf_push_o,
    output logic                                  buf_pop_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] dac_data_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] config_1_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] config_2_o,
    output logic [dma_csr_map_pkg::CSR_DATA_W-1:0] pkt_count_o
);

    import dma_csr_map_pkg::*;

    // Decoded access, one cycle behind req_i
    logic [SEL_W-1:0]      sel;
    logic                  wr;
    logic                  rd;
    logic [CSR_DATA_W-1:0] wr_data;

    csr_access_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .wr_en_i   (wr_en_i),
        .addr_i    (addr_i),
        .wr_data_i (wr_data_i),
        .sel_o     (sel),
        .wr_o      (wr),
        .rd_o      (rd),
        .wr_data_o (wr_data)
    );

    csr_register_bank u_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel_i       (sel),
        .wr_i        (wr),
        .wr_data_i   (wr_data),
        .init_rst_o  (init_rst_o),
        .mwr_start_o (mwr_start_o),
        .buf_addr_o  (buf_addr_o),
        .dac_data_o  (dac_data_o),
        .config_1_o  (config_1_o),
        .config_2_o  (config_2_o),
        .pkt_count_o (pkt_count_o)
    );

    // Reads the bank outputs directly
    csr_read_return u_read (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel_i       (sel),
        .rd_i        (rd),
        .wr_i        (wr),
        .init_rst_i  (init_rst_o),
        .mwr_start_i (mwr_start_o),
        .dac_data_i  (dac_data_o),
        .config_1_i  (config_1_o),
        .config_2_i  (config_2_o),
        .pkt_count_i (pkt_count_o),
        .buf_head_i  (buf_head_i),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o),
        .buf_push_o  (buf_push_o),
        .buf_pop_o   (buf_pop_o)
    );

endmodule

`default_nettype wire

// File: verification/dma_ctrl_csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_csr_tb;

    import dma_csr_map_pkg::*;

    localparam int WAIT_LIMIT = 20;  // Cycles before any wait gives up

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  wr_en;
    logic [CSR_ADDR_W-1:0] addr;
    logic [CSR_DATA_W-1:0] wr_data;
    logic [CSR_DATA_W-1:0] buf_head;
    logic [CSR_DATA_W-1:0] rd_data;
    logic                  rd_valid;
    logic                  init_rst;
    logic                  mwr_start;
    logic [CSR_DATA_W-1:0] buf_addr;
    logic                  buf_push;
    logic                  buf_pop;
    logic [CSR_DATA_W-1:0] dac_data;
    logic [CSR_DATA_W-1:0] config_1;
    logic [CSR_DATA_W-1:0] config_2;
    logic [CSR_DATA_W-1:0] pkt_count;

    integer                seed = 87571;
    int                    error_count = 0;
    int                    check_count = 0;
    int                    push_count = 0;
    int                    pop_count = 0;
    int                    valid_count = 0;
    logic [CSR_DATA_W-1:0] last_push_addr = '0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dma_ctrl_csr_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),
        .wr_en_i     (wr_en),
        .addr_i      (addr),
        .wr_data_i   (wr_data),
        .buf_head_i  (buf_head),
        .rd_data_o   (rd_data),
        .rd_valid_o  (rd_valid),
        .init_rst_o  (init_rst),
        .mwr_start_o (mwr_start),
        .buf_addr_o  (buf_addr),
        .buf_push_o  (buf_push),
        .buf_pop_o   (buf_pop),
        .dac_data_o  (dac_data),
        .config_1_o  (config_1),
        .config_2_o  (config_2),
        .pkt_count_o (pkt_count)
    );

    // Queue and read pulses counted mid-cycle
    always @(negedge clk) begin
        if (buf_push) begin
            push_count++;
            last_push_addr = buf_addr;
        end
        if (buf_pop) begin
            pop_count++;
        end
        if (rd_valid) begin
            valid_count++;
        end
    end

    //----------------------------------------------------------------------
    // Access and check tasks entered 1 ns after a rising edge
    //----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [CSR_DATA_W-1:0] actual,
                               input logic [CSR_DATA_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] a, input logic [CSR_DATA_W-1:0] d);
        req     = 1'b1;
        wr_en   = 1'b1;
        addr    = a;
        wr_data = d;
        @(posedge clk);
        #1 req = 1'b0;
    endtask

    task automatic csr_read(input logic [CSR_ADDR_W-1:0] a, output logic [CSR_DATA_W-1:0] d);
        int waited;
        waited = 0;
        req    = 1'b1;
        wr_en  = 1'b0;
        addr   = a;
        @(posedge clk);
        #1 req = 1'b0;
        while (!rd_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rd_valid) begin
            d = rd_data;
        end else begin
            error_count++;
            d = '0;
            $display("Read of register %0d: read valid never arrived", a);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%-14s done, %0d errors", name, error_count - err_before);
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic reset_defaults();
        int                    err_before;
        int                    valid_base;
        logic [CSR_DATA_W-1:0] rd;
        err_before = error_count;
        valid_base = valid_count;
        check_value("init_rst_o", init_rst, 0);
        check_value("mwr_start_o", mwr_start, 0);
        check_value("buf_addr_o", buf_addr, 0);
        check_value("rd_valid_o", rd_valid, 0);
        check_value("rd_data_o", rd_data, 0);
        check_value("buf_push_o", buf_push, 0);
        check_value("buf_pop_o", buf_pop, 0);
        check_value("config_1_o", config_1, 32'h0002_1FFF);
        csr_read(REG_IDENT, rd);
        check_value("ident", rd, 32'h1402_1600);  // Family 0x14, type 2, version 0x16
        csr_read(REG_DAC, rd);
        check_value("dac", rd, 32'h8080_8080);
        csr_read(REG_CFG1_HI, rd);
        check_value("cfg1_hi", rd, 32'h0000_0010);
        csr_read(REG_FRAME_LEN, rd);
        check_value("frame_len", rd, 32'h0000_1FFF);
        csr_read(REG_CFG2, rd);
        check_value("cfg2", rd, 32'h0002_0000);
        csr_read(REG_PKT_COUNT, rd);
        check_value("pkt_count", rd, 32'h0000_8000);
        csr_read(REG_TEST, rd);
        check_value("test_pattern", rd, 32'hABD0_FFCE);
        csr_read(7'd8, rd);
        check_value("reg8", rd, 32'h0);           // Unmapped
        idle_cycles(2);
        check_value("rd_valid_o count", valid_count - valid_base, 8);  // One pulse per read
        report_test("reset_values", err_before);
    endtask

    task automatic whole_word_readback();
        int                    err_before;
        logic [CSR_DATA_W-1:0] w;
        logic [CSR_DATA_W-1:0] rd;
        err_before = error_count;
        w = $random(seed);
        csr_write(REG_DAC, w);
        csr_read(REG_DAC, rd);                    // Back to back with the write
        check_value("dac", rd, w);
        check_value("dac_data_o", dac_data, w);
        w = $random(seed);
        csr_write(REG_CFG2, w);
        csr_read(REG_CFG2, rd);
        check_value("cfg2", rd, w);
        check_value("config_2_o", config_2, w);
        w = $random(seed);
        csr_write(REG_PKT_COUNT, w);
        csr_read(REG_PKT_COUNT, rd);
        check_value("pkt_count", rd, w);
        check_value("pkt_count_o", pkt_count, w);
        report_test("whole_words", err_before);
    endtask

    task automatic cfg1_window_split();
        int                    err_before;
        logic [CSR_DATA_W-1:0] w;
        logic [CSR_DATA_W-1:0] rd;
        logic [CSR_DATA_W-1:0] model;
        err_before = error_count;
        model = 32'h0002_1FFF;
        w = $random(seed);
        csr_write(REG_CFG1_HI, w);
        model[31:13] = w[18:0];
        csr_read(REG_CFG1_HI, rd);
        check_value("cfg1_hi", rd, {13'h0, w[18:0]});
        csr_read(REG_FRAME_LEN, rd);
        check_value("frame_len", rd, {19'h0, model[12:0]});  // Untouched by upper write
        w = $random(seed);
        csr_write(REG_FRAME_LEN, w);
        model[12:0] = w[12:0];
        csr_read(REG_FRAME_LEN, rd);
        check_value("frame_len", rd, {19'h0, w[12:0]});
        csr_read(REG_CFG1_HI, rd);
        check_value("cfg1_hi", rd, {13'h0, model[31:13]});
        check_value("config_1_o", config_1, model);
        report_test("cfg1_windows", err_before);
    endtask

    task automatic start_and_init_reset();
        int                    err_before;
        logic [CSR_DATA_W-1:0] rd;
        err_before = error_count;
        csr_write(REG_WR_START, 32'h1);
        csr_read(REG_WR_START, rd);
        check_value("wr_start", rd, 32'h1);
        check_value("mwr_start_o", mwr_start, 1);
        csr_write(REG_IDENT, 32'h1);              // Initiator reset kills the start bit
        csr_read(REG_IDENT, rd);
        check_value("ident", rd, 32'h1402_1601);
        check_value("init_rst_o", init_rst, 1);
        check_value("mwr_start_o", mwr_start, 0);
        csr_write(REG_IDENT, 32'h0);
        csr_read(REG_IDENT, rd);
        check_value("ident", rd, 32'h1402_1600);
        check_value("init_rst_o", init_rst, 0);
        report_test("start_reset", err_before);
    endtask

    task automatic buffer_queue_strobes();
        int                    err_before;
        int                    push_base;
        int                    pop_base;
        int                    waited;
        logic [CSR_DATA_W-1:0] w;
        logic [CSR_DATA_W-1:0] rd;
        err_before = error_count;
        push_base  = push_count;
        pop_base   = pop_count;
        w = $random(seed);
        csr_write(REG_BUF_QUEUE, w);
        waited = 0;
        while (push_count == push_base && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (push_count == push_base) begin
            error_count++;
            $display("Queue write: buffer push never arrived");
        end
        idle_cycles(3);
        check_value("buf_push_o count", push_count - push_base, 1);
        check_value("buf_addr_o at push", last_push_addr, w);
        check_value("buf_addr_o", buf_addr, w);
        buf_head = $random(seed);
        csr_read(REG_BUF_QUEUE, rd);
        idle_cycles(3);
        check_value("buf_queue", rd, buf_head);
        check_value("buf_pop_o count", pop_count - pop_base, 1);
        check_value("buf_push_o count", push_count - push_base, 1);
        // Other registers leave the queue alone
        push_base = push_count;
        pop_base  = pop_count;
        csr_write(REG_DAC, $random(seed));
        csr_read(REG_DAC, rd);
        idle_cycles(3);
        check_value("buf_push_o count", push_count - push_base, 0);
        check_value("buf_pop_o count", pop_count - pop_base, 0);
        report_test("buffer_queue", err_before);
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin
        int waited;
        req      = 1'b0;
        wr_en    = 1'b0;
        addr     = '0;
        wr_data  = '0;
        buf_head = '0;
        waited   = 0;
        while (!rst_n && waited < 4 * WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!rst_n) begin
            error_count++;
            $display("Reset was never released");
        end
        idle_cycles(1);

        reset_defaults();
        whole_word_readback();
        cfg1_window_split();
        start_and_init_reset();
        buffer_queue_strobes();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 4;  // 8 ns clock
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire
